//--- include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Bus geometry
`define MEM_ADDR_W  32   // Byte address width
`define MEM_DATA_W  32   // Data bus width
`define MEM_STRB_W  4    // One strobe per byte lane

// SRAM size in 32-bit words
`define MEM_DEPTH   256  // 1 KiB

// Slave latencies, in cycles spent in the busy state
`define RD_LATENCY  3
`define WR_LATENCY  2
`define LAT_CNT_W   4    // Wide enough for both latencies

`endif

//--- hdl/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // AXI-lite channel payloads
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] araddr;
  } ar_chan_t;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] awaddr;
  } aw_chan_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_STRB_W-1:0] wstrb;
  } w_chan_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] rdata;
    axi_resp_e              rresp;
  } r_chan_t;

  typedef struct packed {
    axi_resp_e bresp;
  } b_chan_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_READ, ST_WAIT_RREADY, ST_WAIT_WVALID, ST_WRITE, ST_WAIT_BREADY
  } sram_state_e;

  typedef enum logic [2:0] {
    OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW
  } lsu_op_e;

  typedef enum logic [2:0] {
    LS_IDLE, LS_AR, LS_R, LS_AW_W, LS_B, LS_RESP
  } lsu_state_e;

  // Core side
  typedef struct packed {
    lsu_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   err;    // Misaligned or SLVERR
  } lsu_resp_t;

endpackage

//--- hdl/dsram.sv
`include "mem_settings.svh"

module dsram (
  input  logic              clk,
  input  logic              rst,
  // Read address
  input  mem_pkg::ar_chan_t ar_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  // Read data
  output mem_pkg::r_chan_t  r_o,
  output logic              rvalid_o,
  input  logic              rready_i,
  // Write address
  input  mem_pkg::aw_chan_t aw_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  // Write data
  input  mem_pkg::w_chan_t  w_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  // Write response
  output mem_pkg::b_chan_t  b_o,
  output logic              bvalid_o,
  input  logic              bready_i
);
  import mem_pkg::*;

  localparam int WORD_AW = `MEM_ADDR_W - 2;
  localparam int IDX_W   = $clog2(`MEM_DEPTH);

  sram_state_e            state;
  sram_state_e            next_state;
  logic [`LAT_CNT_W-1:0]  rd_cnt;
  logic [`LAT_CNT_W-1:0]  wr_cnt;
  logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];
  logic [WORD_AW-1:0]     rd_word;
  logic [WORD_AW-1:0]     aw_word_q;    // Write address held until W arrives
  logic                   rd_in_range;
  logic                   wr_in_range;
  logic                   ar_fire;
  logic                   aw_fire;
  logic                   w_fire;
  r_chan_t                r_q;
  b_chan_t                b_q;

  assign arready_o = (state == ST_IDLE);
  assign awready_o = (state == ST_IDLE) && !arvalid_i;  // Read wins a tie
  assign wready_o  = (state == ST_WAIT_WVALID);
  assign rvalid_o  = (state == ST_WAIT_RREADY);
  assign bvalid_o  = (state == ST_WAIT_BREADY);
  assign r_o       = r_q;
  assign b_o       = b_q;

  assign ar_fire = arvalid_i && arready_o;
  assign aw_fire = awvalid_i && awready_o;
  assign w_fire  = wvalid_i && wready_o;

  assign rd_word     = ar_i.araddr[`MEM_ADDR_W-1:2];
  assign rd_in_range = (rd_word < WORD_AW'(`MEM_DEPTH));
  assign wr_in_range = (aw_word_q < WORD_AW'(`MEM_DEPTH));

  // Read word captured on AR acceptance
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r_q.rdata <= rd_in_range ? mem[rd_word[IDX_W-1:0]] : '0;
      r_q.rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_word_q <= aw_i.awaddr[`MEM_ADDR_W-1:2];
    end
    if (w_fire) begin
      b_q.bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      if (wr_in_range) begin
        for (int i = 0; i < `MEM_STRB_W; i++) begin
          if (w_i.wstrb[i]) begin
            mem[aw_word_q[IDX_W-1:0]][8*i +: 8] <= w_i.wdata[8*i +: 8];  // Byte merge
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (arvalid_i) begin
          next_state = ST_READ;
        end else if (awvalid_i) begin
          next_state = ST_WAIT_WVALID;
        end
      end
      ST_READ:        if (rd_cnt >= `LAT_CNT_W'(`RD_LATENCY - 1)) next_state = ST_WAIT_RREADY;
      ST_WAIT_RREADY: if (rready_i) next_state = ST_IDLE;
      ST_WAIT_WVALID: if (wvalid_i) next_state = ST_WRITE;
      ST_WRITE:       if (wr_cnt >= `LAT_CNT_W'(`WR_LATENCY - 1)) next_state = ST_WAIT_BREADY;
      ST_WAIT_BREADY: if (bready_i) next_state = ST_IDLE;
      default:        next_state = ST_IDLE;
    endcase
  end

  // Latency counters run only while in their busy state
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_cnt <= '0;
    end else if (state == ST_READ) begin
      rd_cnt <= rd_cnt + 1'b1;
    end else begin
      rd_cnt <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_cnt <= '0;
    end else if (state == ST_WRITE) begin
      wr_cnt <= wr_cnt + 1'b1;
    end else begin
      wr_cnt <= '0;
    end
  end

endmodule

//--- hdl/lsu_axi_master.sv
`include "mem_settings.svh"

module lsu_axi_master (
  input  logic               clk,
  input  logic               rst,
  // Core side
  input  logic               req_valid_i,
  input  mem_pkg::lsu_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output mem_pkg::lsu_resp_t resp_o,
  input  logic               resp_ready_i,
  // AXI-lite master
  output mem_pkg::ar_chan_t  ar_o,
  output logic               arvalid_o,
  input  logic               arready_i,
  input  mem_pkg::r_chan_t   r_i,
  input  logic               rvalid_i,
  output logic               rready_o,
  output mem_pkg::aw_chan_t  aw_o,
  output logic               awvalid_o,
  input  logic               awready_i,
  output mem_pkg::w_chan_t   w_o,
  output logic               wvalid_o,
  input  logic               wready_i,
  input  mem_pkg::b_chan_t   b_i,
  input  logic               bvalid_i,
  output logic               bready_o
);
  import mem_pkg::*;

  lsu_state_e             state;
  lsu_req_t               req_q;
  lsu_resp_t              resp_q;
  logic                   aw_done;
  logic                   w_done;
  logic                   req_fire;
  logic [1:0]             offset;
  logic [`MEM_DATA_W-1:0] ld_shift;
  logic [`MEM_DATA_W-1:0] ld_data;
  logic [`MEM_STRB_W-1:0] st_strb;

  function automatic logic misaligned(lsu_op_e op, logic [1:0] lo);
    case (op)
      OP_LH, OP_LHU, OP_SH: return lo[0];
      OP_LW, OP_SW:         return |lo;
      default:              return 1'b0;
    endcase
  endfunction

  function automatic logic is_load(lsu_op_e op);
    return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
  endfunction

  assign req_ready_o  = (state == LS_IDLE);
  assign resp_valid_o = (state == LS_RESP);
  assign resp_o       = resp_q;
  assign req_fire     = req_valid_i && req_ready_o;

  assign arvalid_o = (state == LS_AR);
  assign rready_o  = (state == LS_R);
  assign awvalid_o = (state == LS_AW_W) && !aw_done;
  assign wvalid_o  = (state == LS_AW_W) && !w_done;
  assign bready_o  = (state == LS_B);

  assign offset      = req_q.addr[1:0];
  assign ar_o.araddr = {req_q.addr[`MEM_ADDR_W-1:2], 2'b00};  // Word aligned
  assign aw_o.awaddr = {req_q.addr[`MEM_ADDR_W-1:2], 2'b00};
  assign w_o.wdata   = req_q.wdata << {offset, 3'b000};       // Into byte lanes
  assign w_o.wstrb   = st_strb;
  assign ld_shift    = r_i.rdata >> {offset, 3'b000};

  always_comb begin
    case (req_q.op)
      OP_SB:   st_strb = 4'b0001 << offset;
      OP_SH:   st_strb = 4'b0011 << offset;
      default: st_strb = 4'b1111;
    endcase
  end

  always_comb begin
    case (req_q.op)
      OP_LB:   ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};    // Sign extend
      OP_LBU:  ld_data = {24'h0, ld_shift[7:0]};
      OP_LH:   ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
      OP_LHU:  ld_data = {16'h0, ld_shift[15:0]};
      default: ld_data = ld_shift;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state   <= LS_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        LS_IDLE: begin
          if (req_fire) begin
            if (misaligned(req_i.op, req_i.addr[1:0])) begin
              state <= LS_RESP;                         // No bus access
            end else if (is_load(req_i.op)) begin
              state <= LS_AR;
            end else begin
              state <= LS_AW_W;
            end
          end
        end
        LS_AR:   if (arready_i) state <= LS_R;
        LS_R:    if (rvalid_i) state <= LS_RESP;
        LS_AW_W: begin
          if (awvalid_o && awready_i) aw_done <= 1'b1;
          if (wvalid_o && wready_i) w_done <= 1'b1;
          if ((aw_done || awready_i) && (w_done || wready_i)) begin
            state   <= LS_B;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        LS_B:    if (bvalid_i) state <= LS_RESP;
        LS_RESP: if (resp_ready_i) state <= LS_IDLE;
        default: state <= LS_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q        <= req_i;
      resp_q.rdata <= '0;
      resp_q.err   <= misaligned(req_i.op, req_i.addr[1:0]);
    end else if (state == LS_R && rvalid_i) begin
      resp_q.rdata <= (r_i.rresp == RESP_SLVERR) ? '0 : ld_data;
      resp_q.err   <= (r_i.rresp == RESP_SLVERR);
    end else if (state == LS_B && bvalid_i) begin
      resp_q.rdata <= '0;                              // Stores return no data
      resp_q.err   <= (b_i.bresp == RESP_SLVERR);
    end
  end

endmodule

//--- hdl/mem_subsys_top.sv
module mem_subsys_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid_i,
  input  mem_pkg::lsu_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output mem_pkg::lsu_resp_t resp_o,
  input  logic               resp_ready_i
);
  import mem_pkg::*;

  ar_chan_t ar;
  r_chan_t  r;
  aw_chan_t aw;
  w_chan_t  w;
  b_chan_t  b;
  logic     arvalid, arready, rvalid, rready;
  logic     awvalid, awready, wvalid, wready, bvalid, bready;

  lsu_axi_master lsu_axi_master_i (
    .clk, .rst,
    .req_valid_i, .req_i, .req_ready_o,
    .resp_valid_o, .resp_o, .resp_ready_i,
    .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
    .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
    .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
    .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
    .b_i(b), .bvalid_i(bvalid), .bready_o(bready)
  );

  dsram dsram_i (
    .clk, .rst,
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
    .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
    .b_o(b), .bvalid_o(bvalid), .bready_i(bready)
  );

endmodule

//--- verif/tb_mem_subsys.sv
`include "mem_settings.svh"

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int                    TIMEOUT  = 200;
  localparam logic [`MEM_ADDR_W-1:0] END_ADDR = `MEM_DEPTH * 4;  // First byte past the SRAM

  typedef struct packed {
    lsu_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_DATA_W-1:0] exp_rdata;
    logic                   exp_err;
  } vec_t;

  // Each entry sees the memory left by the ones before it
  localparam int   NUM_VECS = 29;
  localparam vec_t VECS [NUM_VECS] = '{
    '{OP_SW,  32'h0000_0000, 32'h0BAD_C0DE, 32'h0000_0000, 1'b0},
    '{OP_SW,  32'h0000_0010, 32'h1234_5678, 32'h0000_0000, 1'b0},
    '{OP_LW,  32'h0000_0010, 32'h0000_0000, 32'h1234_5678, 1'b0},
    '{OP_SW,  32'h0000_0020, 32'h80F7_7F01, 32'h0000_0000, 1'b0},  // Mixed sign bytes
    '{OP_LB,  32'h0000_0020, 32'h0000_0000, 32'h0000_0001, 1'b0},
    '{OP_LB,  32'h0000_0021, 32'h0000_0000, 32'h0000_007F, 1'b0},
    '{OP_LB,  32'h0000_0022, 32'h0000_0000, 32'hFFFF_FFF7, 1'b0},
    '{OP_LB,  32'h0000_0023, 32'h0000_0000, 32'hFFFF_FF80, 1'b0},
    '{OP_LBU, 32'h0000_0020, 32'h0000_0000, 32'h0000_0001, 1'b0},
    '{OP_LBU, 32'h0000_0021, 32'h0000_0000, 32'h0000_007F, 1'b0},
    '{OP_LBU, 32'h0000_0022, 32'h0000_0000, 32'h0000_00F7, 1'b0},
    '{OP_LBU, 32'h0000_0023, 32'h0000_0000, 32'h0000_0080, 1'b0},
    '{OP_LH,  32'h0000_0020, 32'h0000_0000, 32'h0000_7F01, 1'b0},
    '{OP_LH,  32'h0000_0022, 32'h0000_0000, 32'hFFFF_80F7, 1'b0},
    '{OP_LHU, 32'h0000_0020, 32'h0000_0000, 32'h0000_7F01, 1'b0},
    '{OP_LHU, 32'h0000_0022, 32'h0000_0000, 32'h0000_80F7, 1'b0},
    '{OP_SW,  32'h0000_0030, 32'h1122_3344, 32'h0000_0000, 1'b0},
    '{OP_SB,  32'h0000_0032, 32'h5A5A_5AAB, 32'h0000_0000, 1'b0},  // Only byte 2 lands
    '{OP_SH,  32'h0000_0030, 32'hC3C3_BEEF, 32'h0000_0000, 1'b0},
    '{OP_LW,  32'h0000_0030, 32'h0000_0000, 32'h11AB_BEEF, 1'b0},
    '{OP_LH,  32'h0000_0021, 32'h0000_0000, 32'h0000_0000, 1'b1},  // Misaligned
    '{OP_LW,  32'h0000_0012, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_SH,  32'h0000_0013, 32'h0000_FFFF, 32'h0000_0000, 1'b1},
    '{OP_SW,  32'h0000_0011, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1},
    '{OP_LW,  32'h0000_0010, 32'h0000_0000, 32'h1234_5678, 1'b0},  // Word untouched
    '{OP_SW,  END_ADDR,      32'hCAFE_F00D, 32'h0000_0000, 1'b1},  // Out of range
    '{OP_LW,  END_ADDR,      32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_LW,  32'hFFFF_FFFC, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_LW,  32'h0000_0000, 32'h0000_0000, 32'h0BAD_C0DE, 1'b0}   // No wrap to word 0
  };

  logic      clk;
  logic      rst;
  logic      req_valid_i;
  lsu_req_t  req_i;
  logic      req_ready_o;
  logic      resp_valid_o;
  lsu_resp_t resp_o;
  logic      resp_ready_i;
  integer    seed = 32'h93d1_e73a;
  int        errors;
  bit        timed_out;

  mem_subsys_top mem_subsys_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR @%0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic run_vec(input int idx);
    vec_t        v;
    lsu_resp_t   held;
    logic [31:0] rnd;
    int          waited;
    v = VECS[idx];
    req_valid_i = 1'b1;
    req_i       = '{op: v.op, addr: v.addr, wdata: v.wdata};
    waited = 0;
    while (!req_ready_o && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!req_ready_o) begin
      $display("Timeout: request %0d was never accepted", idx);
      timed_out = 1'b1;
      return;
    end
    next_cycle();                                      // Accepted on this edge
    req_valid_i = 1'b0;
    waited = 1;                                        // Acceptance cycle counts
    while (!resp_valid_o && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!resp_valid_o) begin
      $display("Timeout: no response for request %0d", idx);
      timed_out = 1'b1;
      return;
    end
    if (!(v.op inside {OP_SB, OP_SH, OP_SW}) && !v.exp_err) begin
      assert (waited >= `RD_LATENCY + 3) else begin
        $display("ERR @%0d ns: load %0d answered after %0d cycles", $time, idx, waited);
        errors++;
      end
    end
    held = resp_o;
    rnd  = $random(seed);
    repeat (rnd[1:0]) begin                            // Back-pressure
      next_cycle();
      check_value("resp_valid while stalled", 32'(resp_valid_o), 32'h1);
      check_value("rdata while stalled", resp_o.rdata, held.rdata);
      check_value("err while stalled", 32'(resp_o.err), 32'(held.err));
    end
    resp_ready_i = 1'b1;
    check_value($sformatf("rdata of entry %0d", idx), resp_o.rdata, v.exp_rdata);
    check_value($sformatf("err of entry %0d", idx), 32'(resp_o.err), 32'(v.exp_err));
    next_cycle();
    resp_ready_i = 1'b0;
    check_value("resp_valid after handshake", 32'(resp_valid_o), 32'h0);  // Not repeated
  endtask

  initial begin
    rst          = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    errors       = 0;
    timed_out    = 1'b0;
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b1;
    check_value("req_ready after reset", 32'(req_ready_o), 32'h1);
    check_value("resp_valid after reset", 32'(resp_valid_o), 32'h0);
    check_value("arvalid after reset", 32'(mem_subsys_top_i.arvalid), 32'h0);
    check_value("awvalid after reset", 32'(mem_subsys_top_i.awvalid), 32'h0);
    check_value("wvalid after reset", 32'(mem_subsys_top_i.wvalid), 32'h0);
    check_value("rvalid after reset", 32'(mem_subsys_top_i.rvalid), 32'h0);
    check_value("bvalid after reset", 32'(mem_subsys_top_i.bvalid), 32'h0);
    check_value("arready after reset", 32'(mem_subsys_top_i.arready), 32'h1);
    check_value("awready after reset", 32'(mem_subsys_top_i.awready), 32'h1);
    for (int i = 0; i < NUM_VECS; i++) begin
      run_vec(i);
      if (timed_out) break;
    end
    $display("Summary: %0d errors, %0d timeouts", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hdl/mem_pkg.sv
hdl/dsram.sv
hdl/lsu_axi_master.sv
hdl/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_mem_subsys -f files.f -o tb_mem_subsys > build.log 2>&1 \
  && ./obj_dir/tb_mem_subsys > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation finished without failures"
